// ==== all.f ====
rtl/atom_pkg.sv
rtl/atom_clken.sv
rtl/atom_bus.sv
rtl/atom_pia.sv
rtl/atom_cassette.sv
rtl/atom_video_ram.sv
rtl/atom_top.sv
testbench/atom_assert.sv
testbench/tb_atom.sv

// ==== rtl/atom_bus.sv ====
`timescale 1ns/1ps
`default_nettype none
// ======================================================================
// CPU bus register, address decode and read data multiplexer
// Also drives the external SRAM and masks writes into ROM space
// ======================================================================

module atom_bus
   import atom_pkg::*;
(
   input  wire       clk25,
   input  wire       pwr_up_reset_n,
   input  wire       cpu_clken,
   input  wire       we_gate,
   input  cpu_bus_t  cpu_in,
   output cpu_bus_t  bus,
   output logic      pia_cs,
   output logic      vid_we,
   input  data_t     pia_rdata,
   input  data_t     vid_rdata,
   input  data_t     ram_rdata,
   output data_t     cpu_rdata,
   output ext_addr_t ram_addr,
   output data_t     ram_wdata,
   output logic      ram_oe_n,
   output logic      ram_we_n
);

   // Region selects
   logic rom_cs;
   logic ram_cs;
   logic vid_cs;

   // ===================================================================
   // Bus capture
   // ===================================================================

   // CPU outputs settle one enable ahead, so hold them here
   always_ff @(posedge clk25)
   begin
      if (!pwr_up_reset_n)
      begin
         bus.addr  <= '0;
         bus.wdata <= '0;
         // Idle as a read
         bus.rnw   <= 1'b1;
      end
      else if (cpu_clken)
      begin
         bus <= cpu_in;
      end
   end

   // ===================================================================
   // Address decode
   // ===================================================================

   assign rom_cs = (bus.addr[15:14] == ROM_PREFIX);
   // SRAM holds both RAM and ROM images
   assign ram_cs = (bus.addr[15] == RAM_PREFIX) || rom_cs;
   assign vid_cs = (bus.addr[15:13] == VID_PREFIX);
   assign pia_cs = (bus.addr[15:10] == PIA_PREFIX);

   // Video port A write, level for the whole bus window
   assign vid_we = vid_cs && !bus.rnw;

   // ===================================================================
   // External SRAM
   // ===================================================================

   assign ram_addr  = {2'b00, bus.addr};
   assign ram_wdata = bus.wdata;
   assign ram_oe_n  = !bus.rnw;
   // One cycle strobe, never into ROM
   assign ram_we_n  = !(we_gate && !bus.rnw && !rom_cs);

   // ===================================================================
   // Read data
   // ===================================================================

   always_comb
   begin
      if (ram_cs)
         cpu_rdata = ram_rdata;
      else if (vid_cs)
         cpu_rdata = vid_rdata;
      else if (pia_cs)
         cpu_rdata = pia_rdata;
      else
         // Bus capacitance and pull downs leave this pattern
         cpu_rdata = bus.addr[15:8] & UNMAPPED_MASK;
   end

endmodule

`default_nettype wire

// ==== rtl/atom_cassette.sv ====
`timescale 1ns/1ps
`default_nettype none
// ======================================================================
// Cassette tone generator and output gating
// Tone toggles every CAS_DIV CPU enables
// ======================================================================

module atom_cassette
   import atom_pkg::*;
(
   input  wire        clk25,
   input  wire        pwr_up_reset_n,
   input  wire        cpu_clken,
   input  wire  [3:0] pc_out,
   output logic       cas_tone,
   output logic       cas_out,
   output logic       sound
);

   // Enables counted in this half-period
   logic [$clog2(CAS_DIV)-1:0] cas_cnt;

   always_ff @(posedge clk25)
   begin
      if (!pwr_up_reset_n)
      begin
         cas_cnt  <= '0;
         cas_tone <= 1'b0;
      end
      else if (cpu_clken)
      begin
         if (cas_cnt == CAS_DIV - 1)
         begin
            cas_cnt  <= '0;
            cas_tone <= !cas_tone;
         end
         else
            cas_cnt <= cas_cnt + 1'b1;
      end
   end

   // Same two NAND gates and inverter as the board
   assign cas_out = !(!(!cas_tone && pc_out[1]) && pc_out[0]);

   // Speaker straight from PC2
   assign sound = pc_out[2];

endmodule

`default_nettype wire

// ==== rtl/atom_clken.sv ====
`timescale 1ns/1ps
`default_nettype none
// ======================================================================
// CPU clock enable generator
// Divides clk25 into 1, 2, 4 or 8 MHz strobes by the turbo setting
// we_gate follows cpu_clken by one cycle for the SRAM write strobe
// ======================================================================

module atom_clken
   import atom_pkg::*;
(
   input  wire    clk25,
   input  wire    pwr_up_reset_n,
   input  turbo_t turbo,
   output logic   cpu_clken,
   output logic   we_gate
);

   // Period counter, 0 to 24
   logic [$clog2(CLKDIV_PERIOD)-1:0] clkdiv;

   // Low counter bits that must be zero for a pulse
   logic [3:0] low_mask;

   // Fewer masked bits means more pulses per period
   always_comb
   begin
      case (turbo)
         TURBO_1MHZ: low_mask = 4'b1111;
         TURBO_2MHZ: low_mask = 4'b0111;
         TURBO_4MHZ: low_mask = 4'b0011;
         default:    low_mask = 4'b0001;
      endcase
   end

   always_ff @(posedge clk25)
   begin
      if (!pwr_up_reset_n)
      begin
         clkdiv    <= '0;
         cpu_clken <= 1'b0;
         we_gate   <= 1'b0;
      end
      else
      begin
         // Wrap at the end of the period
         if (clkdiv == CLKDIV_PERIOD - 1)
            clkdiv <= '0;
         else
            clkdiv <= clkdiv + 1'b1;

         // Only the first 16 counts can pulse
         cpu_clken <= !clkdiv[4] && ((clkdiv[3:0] & low_mask) == 4'b0000);

         // Write gate lands one cycle into the bus window
         we_gate <= cpu_clken;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/atom_pia.sv ====
`timescale 1ns/1ps
`default_nettype none
// ======================================================================
// 8255 PIA model with fixed directions
// PA and PC low nibble are outputs, PB and PC high nibble are inputs
// ======================================================================

module atom_pia
   import atom_pkg::*;
(
   input  wire        clk25,
   input  wire        pwr_up_reset_n,
   input  wire        cpu_clken,
   input  cpu_bus_t   bus,
   input  wire        pia_cs,
   input  kbd_t       kbd,
   input  wire        cas_in,
   input  wire        cas_tone,
   input  wire        fs_n,
   output data_t      pia_rdata,
   output logic [3:0] kbd_row,
   output logic [3:0] vdg_mode,
   output logic [3:0] pc_out
);

   // Output latches
   data_t      pa_r;
   logic [3:0] pc_r;

   // Write strobe for this enable
   logic       pia_wr;

   assign pia_wr = cpu_clken && pia_cs && !bus.rnw;

   // ===================================================================
   // Output latches
   // ===================================================================

   always_ff @(posedge clk25)
   begin
      if (!pwr_up_reset_n)
      begin
         pa_r <= '0;
         pc_r <= '0;
      end
      else if (pia_wr)
      begin
         case (bus.addr[1:0])
            PIA_PA:   pa_r <= bus.wdata;
            PIA_PC:   pc_r <= bus.wdata[3:0];
            PIA_CTRL:
            begin
               // Bit set and reset on port C, mode words ignored
               if (!bus.wdata[7])
                  pc_r[bus.wdata[2:1]] <= bus.wdata[0];
            end
            default:  ;
         endcase
      end
   end

   // ===================================================================
   // Read mux
   // ===================================================================

   always_comb
   begin
      case (bus.addr[1:0])
         PIA_PA:  pia_rdata = pa_r;
         PIA_PB:  pia_rdata = {kbd.shift_n, kbd.ctrl_n, kbd.keyout};
         PIA_PC:  pia_rdata = {fs_n, kbd.rept_n, cas_in, cas_tone, pc_r};
         // Control register reads as zero
         default: pia_rdata = '0;
      endcase
   end

   // Row select low, display mode high
   assign kbd_row  = pa_r[3:0];
   assign vdg_mode = pa_r[7:4];
   assign pc_out   = pc_r;

endmodule

`default_nettype wire

// ==== rtl/atom_pkg.sv ====
`default_nettype none
// ======================================================================
// Shared types and constants for the Atom system glue
// Address map, turbo encoding and the bus and keyboard bundles
// Imported by wildcard into every RTL module
// ======================================================================

package atom_pkg;

   // ===================================================================
   // Basic bus types
   // ===================================================================

   // CPU address and data
   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;

   // External SRAM address, 256 KB part
   typedef logic [17:0] ext_addr_t;

   // CPU speed select, as set from the keyboard
   typedef enum logic [1:0]
   {
      TURBO_1MHZ = 2'b00,
      TURBO_2MHZ = 2'b01,
      TURBO_4MHZ = 2'b10,
      TURBO_8MHZ = 2'b11
   } turbo_t;

   // CPU bus as captured on the clock enable
   typedef struct packed
   {
      addr_t addr;
      data_t wdata;
      logic  rnw;
   } cpu_bus_t;

   // Keyboard matrix lines into PIA port B and C
   typedef struct packed
   {
      logic [5:0] keyout;
      logic       shift_n;
      logic       ctrl_n;
      logic       rept_n;
   } kbd_t;

   // ===================================================================
   // Timing constants
   // ===================================================================

   // clk25 cycles per counter period
   localparam int CLKDIV_PERIOD = 25;
   // CPU enables per cassette tone half-period
   localparam int CAS_DIV = 208;
   // 8 KB video RAM
   localparam int VID_ADDR_W = 13;
   // Floating data bus pattern
   localparam data_t UNMAPPED_MASK = 8'hF1;

   // Region prefixes, top address bits
   localparam logic [1:0] ROM_PREFIX = 2'b11;
   localparam logic       RAM_PREFIX = 1'b0;
   localparam logic [2:0] VID_PREFIX = 3'b100;
   localparam logic [5:0] PIA_PREFIX = 6'b101100;

   // 8255 register offsets
   localparam logic [1:0] PIA_PA   = 2'd0;
   localparam logic [1:0] PIA_PB   = 2'd1;
   localparam logic [1:0] PIA_PC   = 2'd2;
   localparam logic [1:0] PIA_CTRL = 2'd3;

endpackage

`default_nettype wire

// ==== rtl/atom_top.sv ====
`timescale 1ns/1ps
`default_nettype none
// ======================================================================
// Atom system glue top level
// CPU bus, SRAM, keyboard lines, cassette and video port B at the pins
// ======================================================================

module atom_top
   import atom_pkg::*;
(
   input  wire                  clk25,
   input  wire                  pwr_up_reset_n,
   input  wire                  break_n,
   input  turbo_t               turbo,
   // CPU side
   input  cpu_bus_t             cpu_in,
   output data_t                cpu_rdata,
   output logic                 cpu_clken,
   output logic                 cpu_reset,
   // External SRAM
   output ext_addr_t            ram_addr,
   output data_t                ram_wdata,
   output logic                 ram_oe_n,
   output logic                 ram_we_n,
   input  data_t                ram_rdata,
   // Keyboard
   input  kbd_t                 kbd,
   output logic [3:0]           kbd_row,
   // Cassette and sound
   input  wire                  cas_in,
   output logic                 cas_out,
   output logic                 sound,
   // Video
   input  wire                  fs_n,
   output logic [3:0]           vdg_mode,
   output logic                 css,
   input  wire [VID_ADDR_W-1:0] vid_addr,
   output data_t                vid_data
);

   // ===================================================================
   // Internal nets
   // ===================================================================

   logic       we_gate;
   cpu_bus_t   bus;
   logic       pia_cs;
   logic       vid_we;
   data_t      pia_rdata;
   data_t      vid_rdata;
   logic [3:0] pc_out;
   logic       cas_tone;

   // CPU held in reset by power up or BREAK
   assign cpu_reset = !(pwr_up_reset_n && break_n);

   // Colour set select from PC3
   assign css = pc_out[3];

   // ===================================================================
   // Blocks
   // ===================================================================

   atom_clken u_clken
   (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .turbo          (turbo),
      .cpu_clken      (cpu_clken),
      .we_gate        (we_gate)
   );

   atom_bus u_bus
   (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .cpu_clken      (cpu_clken),
      .we_gate        (we_gate),
      .cpu_in         (cpu_in),
      .bus            (bus),
      .pia_cs         (pia_cs),
      .vid_we         (vid_we),
      .pia_rdata      (pia_rdata),
      .vid_rdata      (vid_rdata),
      .ram_rdata      (ram_rdata),
      .cpu_rdata      (cpu_rdata),
      .ram_addr       (ram_addr),
      .ram_wdata      (ram_wdata),
      .ram_oe_n       (ram_oe_n),
      .ram_we_n       (ram_we_n)
   );

   atom_pia u_pia
   (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .cpu_clken      (cpu_clken),
      .bus            (bus),
      .pia_cs         (pia_cs),
      .kbd            (kbd),
      .cas_in         (cas_in),
      .cas_tone       (cas_tone),
      .fs_n           (fs_n),
      .pia_rdata      (pia_rdata),
      .kbd_row        (kbd_row),
      .vdg_mode       (vdg_mode),
      .pc_out         (pc_out)
   );

   atom_cassette u_cassette
   (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .cpu_clken      (cpu_clken),
      .pc_out         (pc_out),
      .cas_tone       (cas_tone),
      .cas_out        (cas_out),
      .sound          (sound)
   );

   // Port A offset is the low address bits of the 8000 window
   atom_video_ram u_video_ram
   (
      .clk25          (clk25),
      .vid_we         (vid_we),
      .addr_a         (bus.addr[VID_ADDR_W-1:0]),
      .wdata          (bus.wdata),
      .rdata_a        (vid_rdata),
      .addr_b         (vid_addr),
      .rdata_b        (vid_data)
   );

endmodule

`default_nettype wire

// ==== rtl/atom_video_ram.sv ====
`timescale 1ns/1ps
`default_nettype none
// ======================================================================
// 8 KB dual-port video RAM
// Port A is the CPU side, port B feeds the display fetch
// ======================================================================

module atom_video_ram
   import atom_pkg::*;
(
   input  wire                  clk25,
   input  wire                  vid_we,
   input  wire [VID_ADDR_W-1:0] addr_a,
   input  data_t                wdata,
   output data_t                rdata_a,
   input  wire [VID_ADDR_W-1:0] addr_b,
   output data_t                rdata_b
);

   // Storage
   data_t mem [2**VID_ADDR_W];

   // CPU port, write and registered read
   always_ff @(posedge clk25)
   begin
      if (vid_we)
         mem[addr_a] <= wdata;
      rdata_a <= mem[addr_a];
   end

   // Display port, read only
   always_ff @(posedge clk25)
   begin
      rdata_b <= mem[addr_b];
   end

endmodule

`default_nettype wire

// ==== testbench/atom_assert.sv ====
`timescale 1ns/1ps
`default_nettype none
// ======================================================================
// Concurrent checks on the Atom top level, bound into atom_top
// ======================================================================

module atom_assert
   import atom_pkg::*;
(
   input wire        clk25,
   input wire        pwr_up_reset_n,
   input wire        cpu_clken,
   input wire        ram_we_n,
   input ext_addr_t  ram_addr,
   input wire        cas_out,
   input wire  [3:0] pc_out,
   input wire        cas_tone
);

   // Failures seen so far, read back by the testbench
   int error_count = 0;

   // Enable is a single cycle strobe
   clken_single: assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      cpu_clken |=> !cpu_clken)
   else
   begin
      error_count++;
      $error("cpu_clken high on two cycles running");
   end

   // SRAM write strobe never reaches the ROM images
   we_below_rom: assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      !ram_we_n |-> (ram_addr < 18'h0C000))
   else
   begin
      error_count++;
      $error("ram_we_n low with ram_addr at or above C000");
   end

   // NOT PC0, or PC1 with the tone low
   cas_gate: assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      cas_out == (!pc_out[0] || (pc_out[1] && !cas_tone)))
   else
   begin
      error_count++;
      $error("cas_out does not follow PC0, PC1 and the tone");
   end

endmodule

`default_nettype wire

// ==== testbench/tb_atom.sv ====
`timescale 1ns/1ps
`default_nettype none
// ======================================================================
// Testbench for the Atom system glue, acting as the CPU on the bus
// Runs a table of bus operations, then enable rate, BREAK and tone tests
// ======================================================================

module tb_atom
   import atom_pkg::*;
();

   localparam int NUM_OPS = 24;
   // Reset, rate, BREAK and tone tests after the table
   localparam int TAIL_CYCLES = 4 * (10 * CLKDIV_PERIOD + 2) + 4 * CAS_DIV * CLKDIV_PERIOD / 8
                                + 400;
   localparam int WATCHDOG_CYCLES = NUM_OPS * CLKDIV_PERIOD * 4 + TAIL_CYCLES;

   // DUT pins
   logic                  clk25;
   logic                  pwr_up_reset_n;
   logic                  break_n;
   turbo_t                turbo;
   cpu_bus_t              cpu_in;
   data_t                 cpu_rdata;
   logic                  cpu_clken;
   logic                  cpu_reset;
   ext_addr_t             ram_addr;
   data_t                 ram_wdata;
   logic                  ram_oe_n;
   logic                  ram_we_n;
   data_t                 ram_rdata = '0;
   kbd_t                  kbd;
   logic [3:0]            kbd_row;
   logic                  cas_in;
   logic                  cas_out;
   logic                  sound;
   logic                  fs_n;
   logic [3:0]            vdg_mode;
   logic                  css;
   logic [VID_ADDR_W-1:0] vid_addr;
   data_t                 vid_data;

   // Stimulus table
   string  op_name  [NUM_OPS];
   logic   op_rnw   [NUM_OPS];
   addr_t  op_addr  [NUM_OPS];
   data_t  op_wdata [NUM_OPS];
   data_t  op_exp   [NUM_OPS];
   turbo_t op_turbo [NUM_OPS];
   int     n_ops;

   // Bookkeeping
   int          errors;
   int          checks;
   int          tests;
   logic [31:0] rng;

   // External SRAM contents
   data_t sram [2**$bits(ext_addr_t)];

   atom_top DUT
   (
      .clk25 (clk25), .pwr_up_reset_n (pwr_up_reset_n), .break_n (break_n),
      .turbo (turbo), .cpu_in (cpu_in), .cpu_rdata (cpu_rdata),
      .cpu_clken (cpu_clken), .cpu_reset (cpu_reset), .ram_addr (ram_addr),
      .ram_wdata (ram_wdata), .ram_oe_n (ram_oe_n), .ram_we_n (ram_we_n),
      .ram_rdata (ram_rdata), .kbd (kbd), .kbd_row (kbd_row), .cas_in (cas_in),
      .cas_out (cas_out), .sound (sound), .fs_n (fs_n), .vdg_mode (vdg_mode),
      .css (css), .vid_addr (vid_addr), .vid_data (vid_data)
   );

   bind atom_top atom_assert u_assert
   (
      .clk25 (clk25), .pwr_up_reset_n (pwr_up_reset_n), .cpu_clken (cpu_clken),
      .ram_we_n (ram_we_n), .ram_addr (ram_addr), .cas_out (cas_out),
      .pc_out (pc_out), .cas_tone (cas_tone)
   );

   initial
   begin
      clk25 = 1'b0;
      forever #20 clk25 = ~clk25;
   end

   // SRAM model, registered read
   always @(posedge clk25)
   begin
      if (!ram_we_n)
         sram[ram_addr] <= ram_wdata;
      ram_rdata <= sram[ram_addr];
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk25);
      $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("Simulation FAILED");
      $finish;
   end

   // ===================================================================
   // Helpers
   // ===================================================================

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // Preload pattern over all 18 address bits
   function automatic data_t fill_byte(input ext_addr_t a);
      return a[7:0] ^ a[15:8] ^ {6'b000000, a[17:16]} ^ 8'h6D;
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests++;
      $display("%-20s %s", name, (errors == errs_before) ? "ok" : "mismatch");
   endtask

   // Stop at a falling edge with the enable high
   task automatic wait_enable();
      @(negedge clk25);
      while (!cpu_clken)
         @(negedge clk25);
   endtask

   // Stop just after the next capture edge
   task automatic next_enable();
      wait_enable();
      @(posedge clk25);
   endtask

   task automatic add_op(input string name, input logic rnw, input addr_t addr,
                         input data_t wdata, input data_t exp, input turbo_t speed);
      op_name[n_ops]  = name;
      op_rnw[n_ops]   = rnw;
      op_addr[n_ops]  = addr;
      op_wdata[n_ops] = wdata;
      op_exp[n_ops]   = exp;
      op_turbo[n_ops] = speed;
      n_ops++;
   endtask

   // One bus operation, entered and left on a capture edge
   task automatic run_op(input string name, input logic rnw, input addr_t addr,
                         input data_t wdata, input data_t exp, input turbo_t speed);
      int   errs_before;
      logic is_vid;
      logic exp_we_n;
      errs_before = errors;
      is_vid      = (addr[15:13] == VID_PREFIX);
      exp_we_n    = rnw || (addr[15:14] == ROM_PREFIX);
      rng         = lcg_next(rng);
      cpu_in   <= {addr, wdata, rnw};
      turbo    <= speed;
      // Display fetch follows the CPU byte on video ops
      vid_addr <= is_vid ? addr[VID_ADDR_W-1:0] : rng[16 +: VID_ADDR_W];
      next_enable();
      // First cycle of the bus window, write gate high
      @(negedge clk25);
      check({name, "_oe_n"}, !rnw, ram_oe_n);
      check({name, "_we_n"}, exp_we_n, ram_we_n);
      if (!exp_we_n)
      begin
         check({name, "_addr"}, {2'b00, addr}, ram_addr);
         check({name, "_wdata"}, wdata, ram_wdata);
      end
      wait_enable();
      if (rnw)
      begin
         check(name, exp, cpu_rdata);
         if (is_vid)
            check({name, "_port_b"}, exp, vid_data);
      end
      @(posedge clk25);
      report_test(name, errs_before);
   endtask

   // ===================================================================
   // Test sequence
   // ===================================================================

   initial
   begin
      int   cnt;
      int   low_cnt;
      int   errs_before;
      int   assert_errs;
      logic lvl;
      errors = 0;
      checks = 0;
      tests  = 0;
      n_ops  = 0;
      rng    = 32'd41;
      for (int a = 0; a < 2**$bits(ext_addr_t); a++)
         sram[a] = fill_byte(ext_addr_t'(a));

      // Idle inputs
      rng            = lcg_next(rng);
      kbd            = kbd_t'(rng[24:16]);
      pwr_up_reset_n = 1'b0;
      break_n        = 1'b1;
      turbo          = TURBO_1MHZ;
      cpu_in         = {16'h0000, 8'h00, 1'b1};
      cas_in         = 1'b1;
      fs_n           = 1'b0;
      vid_addr       = '0;

      // Name, rnw, address, write data, expected read, speed
      add_op("ram_wr_0123",   1'b0, 16'h0123, 8'h5A, 8'h00, TURBO_1MHZ);
      add_op("ram_rd_0123",   1'b1, 16'h0123, 8'h00, 8'h5A, TURBO_1MHZ);
      add_op("ram_wr_7ffe",   1'b0, 16'h7FFE, 8'hC3, 8'h00, TURBO_2MHZ);
      add_op("ram_rd_7ffe",   1'b1, 16'h7FFE, 8'h00, 8'hC3, TURBO_2MHZ);
      add_op("rom_wr_c000",   1'b0, 16'hC000, 8'h99, 8'h00, TURBO_4MHZ);
      add_op("rom_rd_c000",   1'b1, 16'hC000, 8'h00, fill_byte(18'h0C000), TURBO_4MHZ);
      add_op("rom_wr_ffff",   1'b0, 16'hFFFF, 8'h12, 8'h00, TURBO_8MHZ);
      add_op("rom_rd_ffff",   1'b1, 16'hFFFF, 8'h00, fill_byte(18'h0FFFF), TURBO_8MHZ);
      add_op("vid_wr_8123",   1'b0, 16'h8123, 8'hA5, 8'h00, TURBO_8MHZ);
      add_op("vid_rd_8123",   1'b1, 16'h8123, 8'h00, 8'hA5, TURBO_8MHZ);
      add_op("vid_wr_9fff",   1'b0, 16'h9FFF, 8'h3C, 8'h00, TURBO_4MHZ);
      add_op("vid_rd_9fff",   1'b1, 16'h9FFF, 8'h00, 8'h3C, TURBO_2MHZ);
      add_op("pia_pa_wr",     1'b0, 16'hB000, 8'h6B, 8'h00, TURBO_1MHZ);
      add_op("pia_pa_rd",     1'b1, 16'hB000, 8'h00, 8'h6B, TURBO_8MHZ);
      add_op("pia_pb_rd",     1'b1, 16'hB001, 8'h00,
             {kbd.shift_n, kbd.ctrl_n, kbd.keyout}, TURBO_8MHZ);
      add_op("pia_pc_wr",     1'b0, 16'hB002, 8'h02, 8'h00, TURBO_8MHZ);
      // Bit set and reset words, PC becomes 1100
      add_op("pia_bsr_set2",  1'b0, 16'hB003, 8'h05, 8'h00, TURBO_4MHZ);
      add_op("pia_bsr_clr1",  1'b0, 16'hB003, 8'h02, 8'h00, TURBO_4MHZ);
      add_op("pia_bsr_set3",  1'b0, 16'hB003, 8'h07, 8'h00, TURBO_8MHZ);
      // Tone still low this early after reset
      add_op("pia_pc_rd",     1'b1, 16'hB002, 8'h00,
             {fs_n, kbd.rept_n, cas_in, 1'b0, 4'b1100}, TURBO_8MHZ);
      add_op("pia_ctrl_rd",   1'b1, 16'hB003, 8'h00, 8'h00, TURBO_2MHZ);
      add_op("unmapped_a123", 1'b1, 16'hA123, 8'h00, 8'hA1, TURBO_8MHZ);
      add_op("unmapped_b812", 1'b1, 16'hB812, 8'h00, 8'hB0, TURBO_8MHZ);
      add_op("ram_rd_0000",   1'b1, 16'h0000, 8'h00, fill_byte(18'h00000), TURBO_1MHZ);

      // Five reset cycles, state checked inside
      errs_before = errors;
      repeat (2) @(negedge clk25);
      check("reset_cpu_reset", 1'b1, cpu_reset);
      check("reset_ram_we_n", 1'b1, ram_we_n);
      repeat (3) @(posedge clk25);
      pwr_up_reset_n <= 1'b1;
      report_test("reset_state", errs_before);

      next_enable();
      for (int i = 0; i < n_ops; i++)
         run_op(op_name[i], op_rnw[i], op_addr[i], op_wdata[i], op_exp[i], op_turbo[i]);

      // PA on row and mode, PC 1100 on css and sound, PC0 low holds cas_out
      errs_before = errors;
      @(negedge clk25);
      check("kbd_row", 4'hB, kbd_row);
      check("vdg_mode", 4'h6, vdg_mode);
      check("sound", 1'b1, sound);
      check("css", 1'b1, css);
      check("cas_out_pc0_low", 1'b1, cas_out);
      report_test("pia_pins", errs_before);

      // BREAK alone holds the CPU in reset
      errs_before = errors;
      @(posedge clk25);
      break_n <= 1'b0;
      @(negedge clk25);
      check("break_low", 1'b1, cpu_reset);
      @(posedge clk25);
      break_n <= 1'b1;
      @(negedge clk25);
      check("break_high", 1'b0, cpu_reset);
      report_test("break", errs_before);

      // Ten counter periods per turbo setting
      for (int t = 0; t < 4; t++)
      begin
         errs_before = errors;
         @(posedge clk25);
         turbo <= turbo_t'(t);
         repeat (2) @(posedge clk25);
         cnt = 0;
         repeat (10 * CLKDIV_PERIOD)
         begin
            @(negedge clk25);
            if (cpu_clken)
               cnt++;
         end
         check($sformatf("clken_rate_%0d", 1 << t), 10 << t, cnt);
         report_test($sformatf("clken_rate_%0d", 1 << t), errs_before);
      end

      // ================================================================
      // Cassette tone
      // ================================================================

      next_enable();
      run_op("pc_tone_on", 1'b0, 16'hB002, 8'h03, 8'h00, TURBO_8MHZ);
      errs_before = errors;
      // Sync to a tone edge, count enables up to the next one
      @(negedge clk25);
      lvl = cas_out;
      while (cas_out == lvl)
         @(negedge clk25);
      lvl = cas_out;
      cnt = 0;
      while (cas_out == lvl)
      begin
         @(negedge clk25);
         if (cpu_clken)
            cnt++;
      end
      check("tone_half_period", CAS_DIV, cnt);
      report_test("tone_half_period", errs_before);

      // PC0 cleared, output stays high across a tone edge
      next_enable();
      run_op("pc0_reset", 1'b0, 16'hB003, 8'h00, 8'h00, TURBO_8MHZ);
      errs_before = errors;
      cnt     = 0;
      low_cnt = 0;
      while (cnt < CAS_DIV + 8)
      begin
         @(negedge clk25);
         if (cpu_clken)
            cnt++;
         if (cas_out !== 1'b1)
            low_cnt++;
      end
      check("cas_out_held", 0, low_cnt);
      report_test("cas_out_held", errs_before);

      assert_errs = DUT.u_assert.error_count;
      $display("Summary: %0d tests, %0d checks, %0d check errors, %0d assertion failures",
               tests, checks, errors, assert_errs);
      if (errors == 0 && assert_errs == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire
